// ==== verilog/fabric_config.svh ====
// Fabric sizing, stream width, skip marker and DRAM trailer word

`ifndef FABRIC_CONFIG_SVH
`define FABRIC_CONFIG_SVH

// Number of core endpoints behind the fabric
`define FAB_CORE_COUNT 16

// Cores per cluster
// Cluster count is FAB_CORE_COUNT / FAB_CLUSTER_SIZE
`define FAB_CLUSTER_SIZE 4

// Width of the data word on every stream
`define FAB_DATA_WIDTH 64

// Descriptor value that asks for no DRAM request
// All ones except bit 0
`define FAB_SKIP_DESC 64'hFFFF_FFFF_FFFF_FFFE

// Fixed second beat of each DRAM read request
`define FAB_DRAM_TRAILER 64'hDEAD_BEEF_5A5A_A5A5

`endif

// ==== verilog/fabric_pkg.sv ====
// Fabric types: core number, control and DRAM request beats, generator states

`default_nettype none

`include "fabric_config.svh"

package fabric_pkg;

  // Core number, wide enough for every endpoint
  typedef logic [$clog2(`FAB_CORE_COUNT)-1:0] core_id_t;

  // One control descriptor heading out to a core
  typedef struct packed {
    logic [`FAB_DATA_WIDTH-1:0] data;
    core_id_t                   dest;
  } ctrl_beat_t;

  // One beat of a DRAM read request on its way back
  typedef struct packed {
    logic [`FAB_DATA_WIDTH-1:0] data;
    logic                       last;
    core_id_t                   core;
  } dram_beat_t;

  // Request generator FSM
  typedef enum logic [1:0] {
    req_idle,
    req_addr,
    req_trailer
  } req_state_t;

endpackage

`default_nettype wire

// ==== verilog/ctrl_route_stage.sv ====
// Registered one-to-many control stream switch, steered by dest bits

`timescale 1ns/1ps
`default_nettype none

module ctrl_route_stage #(
  parameter int FANOUT  = 4,
  parameter int SEL_LSB = 0
) (
  input  logic                                sys_clk,
  input  logic                                sys_rst,
  input  fabric_pkg::ctrl_beat_t              in_beat,
  input  logic                                in_valid,
  output logic                                in_ready,
  output fabric_pkg::ctrl_beat_t [FANOUT-1:0] out_beat,
  output logic [FANOUT-1:0]                   out_valid,
  input  logic [FANOUT-1:0]                   out_ready
);

  // A single output still needs a one-bit select
  localparam int SEL_W = (FANOUT > 1) ? $clog2(FANOUT) : 1;

  logic [SEL_W-1:0] sel;
  logic             load;

  // Output picked by this beat's destination bits
  assign sel = (FANOUT > 1) ? in_beat.dest[SEL_LSB +: SEL_W] : '0;

  // Accept when the target register is free or empties this cycle,
  // so a stalled output holds up only its own traffic
  assign in_ready = ~out_valid[sel] | out_ready[sel];
  assign load     = in_valid & in_ready;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      out_valid <= '0;
    end else begin
      for (int i = 0; i < FANOUT; i++) begin
        if (load && (sel == SEL_W'(i))) begin
          out_valid[i] <= 1'b1;
        end else if (out_ready[i]) begin
          out_valid[i] <= 1'b0;
        end
      end
    end
  end

  // Payload registers
  always_ff @(posedge sys_clk) begin
    for (int i = 0; i < FANOUT; i++) begin
      if (load && (sel == SEL_W'(i))) begin
        out_beat[i] <= in_beat;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dram_req_gen.sv ====
// Per-core FSM that turns control descriptors into two-beat DRAM read requests

`timescale 1ns/1ps
`default_nettype none

`include "fabric_config.svh"

module dram_req_gen #(
  parameter fabric_pkg::core_id_t CORE_ID = '0
) (
  input  logic                   sys_clk,
  input  logic                   sys_rst,
  input  fabric_pkg::ctrl_beat_t desc,
  input  logic                   desc_valid,
  output logic                   desc_ready,
  output fabric_pkg::dram_beat_t req_beat,
  output logic                   req_valid,
  input  logic                   req_ready
);

  fabric_pkg::req_state_t     state;
  logic [`FAB_DATA_WIDTH-1:0] desc_word;
  logic                       accept;
  logic                       is_skip;

  // Only take a new descriptor between requests
  assign desc_ready = (state == fabric_pkg::req_idle);
  assign accept     = desc_valid & desc_ready;
  assign is_skip    = (desc.data == `FAB_SKIP_DESC);

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state <= fabric_pkg::req_idle;
    end else begin
      case (state)
        // Skip marker is consumed here and leaves the FSM idle
        fabric_pkg::req_idle:
          if (accept && !is_skip) state <= fabric_pkg::req_addr;
        fabric_pkg::req_addr:
          if (req_ready) state <= fabric_pkg::req_trailer;
        fabric_pkg::req_trailer:
          if (req_ready) state <= fabric_pkg::req_idle;
        default:
          state <= fabric_pkg::req_idle;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (accept && !is_skip) begin
      desc_word <= desc.data;
    end
  end

  // Descriptor word first, then the trailer closes the packet
  assign req_valid     = (state == fabric_pkg::req_addr) || (state == fabric_pkg::req_trailer);
  assign req_beat.last = (state == fabric_pkg::req_trailer);
  assign req_beat.data = req_beat.last ? `FAB_DRAM_TRAILER : desc_word;
  assign req_beat.core = CORE_ID;

endmodule

`default_nettype wire

// ==== verilog/dram_req_arb.sv ====
// Round-robin packet arbiter merging DRAM request streams, grant held to last beat

`timescale 1ns/1ps
`default_nettype none

module dram_req_arb #(
  parameter int IN_COUNT = 4
) (
  input  logic                                  sys_clk,
  input  logic                                  sys_rst,
  input  fabric_pkg::dram_beat_t [IN_COUNT-1:0] in_beat,
  input  logic [IN_COUNT-1:0]                   in_valid,
  output logic [IN_COUNT-1:0]                   in_ready,
  output fabric_pkg::dram_beat_t                out_beat,
  output logic                                  out_valid,
  input  logic                                  out_ready
);

  localparam int PTR_W = (IN_COUNT > 1) ? $clog2(IN_COUNT) : 1;

  logic [PTR_W-1:0] grant;
  logic [PTR_W-1:0] rr_ptr;
  logic             busy;
  logic [PTR_W-1:0] pick;
  logic             pick_valid;
  logic [PTR_W-1:0] sel;
  logic             sel_live;
  logic             xfer;

  // Round-robin search, starting one past the previous grant
  always_comb begin
    int idx;
    pick       = '0;
    pick_valid = 1'b0;
    for (int k = 0; k < IN_COUNT; k++) begin
      idx = (int'(rr_ptr) + k) % IN_COUNT;
      if (in_valid[idx] && !pick_valid) begin
        pick       = PTR_W'(idx);
        pick_valid = 1'b1;
      end
    end
  end

  // While idle the fresh pick drives the output in the same cycle
  assign sel      = busy ? grant : pick;
  assign sel_live = busy | pick_valid;

  assign out_beat  = in_beat[sel];
  assign out_valid = sel_live & in_valid[sel];
  assign xfer      = out_valid & out_ready;

  always_comb begin
    for (int i = 0; i < IN_COUNT; i++) begin
      in_ready[i] = out_ready & sel_live & (sel == PTR_W'(i));
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      grant  <= '0;
      rr_ptr <= '0;
      busy   <= 1'b0;
    end else begin
      if (!busy && pick_valid) begin
        grant  <= pick;
        rr_ptr <= PTR_W'((int'(pick) + 1) % IN_COUNT);
      end
      // Packet ends when its last beat leaves
      if (xfer && out_beat.last) begin
        busy <= 1'b0;
      end else if (pick_valid) begin
        busy <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/core_cluster.sv ====
// One core cluster: level-2 route stage, request generators, cluster arbiter

`timescale 1ns/1ps
`default_nettype none

`include "fabric_config.svh"

module core_cluster #(
  parameter int CLUSTER_ID = 0
) (
  input  logic                   sys_clk,
  input  logic                   sys_rst,
  input  fabric_pkg::ctrl_beat_t ctrl,
  input  logic                   ctrl_valid,
  output logic                   ctrl_ready,
  output fabric_pkg::dram_beat_t req,
  output logic                   req_valid,
  input  logic                   req_ready
);

  localparam int CSIZE = `FAB_CLUSTER_SIZE;

  // Control beats per core
  fabric_pkg::ctrl_beat_t [CSIZE-1:0] loc_beat;
  logic [CSIZE-1:0]                   loc_valid;
  logic [CSIZE-1:0]                   loc_ready;

  // DRAM requests per core
  fabric_pkg::dram_beat_t [CSIZE-1:0] gen_beat;
  logic [CSIZE-1:0]                   gen_valid;
  logic [CSIZE-1:0]                   gen_ready;

  // Lower dest bits pick the core inside the cluster
  ctrl_route_stage #(
    .FANOUT  (CSIZE),
    .SEL_LSB (0)
  ) route_lvl2 (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .in_beat   (ctrl),
    .in_valid  (ctrl_valid),
    .in_ready  (ctrl_ready),
    .out_beat  (loc_beat),
    .out_valid (loc_valid),
    .out_ready (loc_ready)
  );

  for (genvar i = 0; i < CSIZE; i++) begin : g_core
    // Global core number from cluster and slot
    dram_req_gen #(
      .CORE_ID (fabric_pkg::core_id_t'(CLUSTER_ID * CSIZE + i))
    ) req_gen (
      .sys_clk    (sys_clk),
      .sys_rst    (sys_rst),
      .desc       (loc_beat[i]),
      .desc_valid (loc_valid[i]),
      .desc_ready (loc_ready[i]),
      .req_beat   (gen_beat[i]),
      .req_valid  (gen_valid[i]),
      .req_ready  (gen_ready[i])
    );
  end

  dram_req_arb #(
    .IN_COUNT (CSIZE)
  ) arb_lvl2 (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .in_beat   (gen_beat),
    .in_valid  (gen_valid),
    .in_ready  (gen_ready),
    .out_beat  (req),
    .out_valid (req_valid),
    .out_ready (req_ready)
  );

endmodule

`default_nettype wire

// ==== verilog/ctrl_dram_fabric.sv ====
// Top level: level-1 control route, core clusters, top DRAM request arbiter

`timescale 1ns/1ps
`default_nettype none

`include "fabric_config.svh"

module ctrl_dram_fabric (
  input  logic                   sys_clk,
  input  logic                   sys_rst,
  input  fabric_pkg::ctrl_beat_t ctrl_in,
  input  logic                   ctrl_in_valid,
  output logic                   ctrl_in_ready,
  output fabric_pkg::dram_beat_t dram_out,
  output logic                   dram_out_valid,
  input  logic                   dram_out_ready
);

  localparam int CLUSTERS = `FAB_CORE_COUNT / `FAB_CLUSTER_SIZE;

  fabric_pkg::ctrl_beat_t [CLUSTERS-1:0] cl_ctrl;
  logic [CLUSTERS-1:0]                   cl_ctrl_valid;
  logic [CLUSTERS-1:0]                   cl_ctrl_ready;

  fabric_pkg::dram_beat_t [CLUSTERS-1:0] cl_req;
  logic [CLUSTERS-1:0]                   cl_req_valid;
  logic [CLUSTERS-1:0]                   cl_req_ready;

  // Upper dest bits pick the cluster
  ctrl_route_stage #(
    .FANOUT  (CLUSTERS),
    .SEL_LSB ($clog2(`FAB_CLUSTER_SIZE))
  ) route_lvl1 (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .in_beat   (ctrl_in),
    .in_valid  (ctrl_in_valid),
    .in_ready  (ctrl_in_ready),
    .out_beat  (cl_ctrl),
    .out_valid (cl_ctrl_valid),
    .out_ready (cl_ctrl_ready)
  );

  for (genvar c = 0; c < CLUSTERS; c++) begin : g_cluster
    core_cluster #(
      .CLUSTER_ID (c)
    ) cluster (
      .sys_clk    (sys_clk),
      .sys_rst    (sys_rst),
      .ctrl       (cl_ctrl[c]),
      .ctrl_valid (cl_ctrl_valid[c]),
      .ctrl_ready (cl_ctrl_ready[c]),
      .req        (cl_req[c]),
      .req_valid  (cl_req_valid[c]),
      .req_ready  (cl_req_ready[c])
    );
  end

  dram_req_arb #(
    .IN_COUNT (CLUSTERS)
  ) arb_lvl1 (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .in_beat   (cl_req),
    .in_valid  (cl_req_valid),
    .in_ready  (cl_req_ready),
    .out_beat  (dram_out),
    .out_valid (dram_out_valid),
    .out_ready (dram_out_ready)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and synchronous reset source

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic sys_clk,
  output logic sys_rst
);

  initial begin
    sys_clk = 1'b0;
    forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
  end

  // Reset released on a rising edge after the hold time
  initial begin
    sys_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    sys_rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== dv/tb_ctrl_dram_fabric.sv ====
// Testbench top: random stimulus, per-core reference queues, compare tasks, timeout

`timescale 1ns/1ps
`default_nettype none

`include "fabric_config.svh"

module tb_ctrl_dram_fabric;

  localparam int NUM_DESC       = 400;
  localparam int BURST_LEN      = 20;
  localparam int STALL_CYCLES   = 16;
  localparam int DRAIN_CYCLES   = 1000;
  localparam int TIMEOUT_CYCLES = NUM_DESC * 40 + 1000;
  localparam int CORES          = `FAB_CORE_COUNT;

  logic                   sys_clk;
  logic                   sys_rst;
  fabric_pkg::ctrl_beat_t ctrl_in;
  logic                   ctrl_in_valid;
  logic                   ctrl_in_ready;
  fabric_pkg::dram_beat_t dram_out;
  logic                   dram_out_valid;
  logic                   dram_out_ready;

  integer seed;
  logic   ready_random;
  logic   ready_hold;
  logic   stall_watch;
  logic   burst_stalled;

  // Reference model: expected words per core, in acceptance order
  logic [`FAB_DATA_WIDTH-1:0] exp_mem [CORES][512];
  int                         head [CORES] = '{default: 0};
  int                         tail [CORES] = '{default: 0};
  int                         nonskip_sent = 0;
  int                         req_count    = 0;
  int                         cycle_count  = 0;
  logic                       in_packet    = 1'b0;
  fabric_pkg::core_id_t       pkt_core;

  tb_clock_gen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (16)
  ) clk_gen (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst)
  );

  ctrl_dram_fabric dut (
    .sys_clk        (sys_clk),
    .sys_rst        (sys_rst),
    .ctrl_in        (ctrl_in),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .dram_out       (dram_out),
    .dram_out_valid (dram_out_valid),
    .dram_out_ready (dram_out_ready)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_beat(input string name, input fabric_pkg::dram_beat_t exp,
                            input fabric_pkg::dram_beat_t act);
    if (act !== exp) begin
      report_failure($sformatf(
        "FAIL %s: expected data=%h last=%b core=%0d, actual data=%h last=%b core=%0d",
        name, exp.data, exp.last, exp.core, act.data, act.last, act.core));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp) begin
      report_failure($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // One clock edge, then the next value of dram_out_ready
  task automatic step();
    logic [31:0] r;
    @(posedge sys_clk);
    if (ready_random) begin
      r = $random(seed);
      dram_out_ready <= r[0];
    end else begin
      dram_out_ready <= ready_hold;
    end
  endtask

  // Steps until every accepted request has left the DUT or the budget runs out
  task automatic wait_for_drain(input int budget);
    int n;
    n = 0;
    while (req_count < nonskip_sent && n < budget) begin
      step();
      n++;
    end
  endtask

  // Offers one descriptor and waits until the DUT takes it
  task automatic send_desc(input logic [`FAB_DATA_WIDTH-1:0] data,
                           input fabric_pkg::core_id_t dest);
    fabric_pkg::ctrl_beat_t beat;
    logic [31:0]            r;
    int                     gap;
    int                     waited;
    logic                   accepted;
    r   = $random(seed);
    gap = (r[1:0] == 2'b00) ? int'(r[3:2]) + 1 : 0;
    repeat (gap) begin
      ctrl_in_valid <= 1'b0;
      step();
    end
    beat.data = data;
    beat.dest = dest;
    ctrl_in       <= beat;
    ctrl_in_valid <= 1'b1;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted) begin
      step();
      if (ctrl_in_ready) begin
        accepted = 1'b1;
      end else begin
        waited++;
        // Long stall in the burst means back-pressure reached the input
        if (stall_watch && waited == STALL_CYCLES) begin
          burst_stalled = 1'b1;
          check_flag("burst_waiting_request", 1'b1, dram_out_valid);
          ready_hold = 1'b1;
        end
      end
    end
    if (data != `FAB_SKIP_DESC) begin
      exp_mem[dest][tail[dest]] = data;
      tail[dest]++;
      nonskip_sent++;
    end
  endtask

  // Output monitor: first beat from the core's queue, then its trailer
  always @(posedge sys_clk) begin : monitor
    int                     c;
    fabric_pkg::dram_beat_t exp_b;
    if (!sys_rst && dram_out_valid && dram_out_ready) begin
      if (!in_packet) begin
        c = int'(dram_out.core);
        if (head[c] == tail[c]) begin
          report_failure($sformatf("Request from core %0d with no descriptor outstanding", c));
        end else begin
          exp_b.data = exp_mem[c][head[c]];
          exp_b.last = 1'b0;
          exp_b.core = fabric_pkg::core_id_t'(c);
          head[c]++;
          check_beat("first_beat", exp_b, dram_out);
          in_packet = 1'b1;
          pkt_core  = exp_b.core;
        end
      end else begin
        exp_b.data = `FAB_DRAM_TRAILER;
        exp_b.last = 1'b1;
        exp_b.core = pkt_core;
        check_beat("trailer_beat", exp_b, dram_out);
        in_packet = 1'b0;
        req_count <= req_count + 1;
      end
    end
  end

  always @(posedge sys_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      report_failure($sformatf("Timeout: run did not finish within %0d clock cycles",
                               TIMEOUT_CYCLES));
    end
  end

  initial begin : stimulus
    logic [31:0]                r;
    logic [31:0]                r_hi;
    logic [31:0]                r_lo;
    logic [`FAB_DATA_WIDTH-1:0] data;
    fabric_pkg::core_id_t       dest;
    int                         base_req;
    seed           = 92;
    ctrl_in        = '0;
    ctrl_in_valid  = 1'b0;
    dram_out_ready = 1'b0;
    ready_random   = 1'b0;
    ready_hold     = 1'b0;
    stall_watch    = 1'b0;
    burst_stalled  = 1'b0;

    do step(); while (sys_rst);
    check_flag("reset_out_valid", 1'b0, dram_out_valid);
    check_flag("reset_in_ready", 1'b1, ctrl_in_ready);

    // Random traffic, roughly one skip marker in ten
    ready_random = 1'b1;
    for (int i = 0; i < NUM_DESC; i++) begin
      r    = $random(seed);
      r_hi = $random(seed);
      r_lo = $random(seed);
      data = (r % 10 == 0) ? `FAB_SKIP_DESC : {r_hi, r_lo};
      r    = $random(seed);
      dest = fabric_pkg::core_id_t'(r);
      send_desc(data, dest);
    end
    ctrl_in_valid <= 1'b0;
    wait_for_drain(DRAIN_CYCLES);
    check_count("random_requests", nonskip_sent, req_count);

    // Burst to one core with the output stalled
    ready_random = 1'b0;
    ready_hold   = 1'b0;
    step();
    base_req    = req_count;
    stall_watch = 1'b1;
    r    = $random(seed);
    dest = fabric_pkg::core_id_t'(r);
    repeat (BURST_LEN) begin
      r_hi = $random(seed);
      r_lo = $random(seed);
      // Bit 0 set keeps it off the skip marker
      send_desc({r_hi, r_lo} | 64'h1, dest);
    end
    ctrl_in_valid <= 1'b0;
    stall_watch = 1'b0;
    check_flag("burst_backpressure", 1'b1, burst_stalled);
    wait_for_drain(DRAIN_CYCLES);
    check_count("burst_delivered", BURST_LEN, req_count - base_req);

    // Quiet period, nothing more may come out
    repeat (20) step();
    check_count("request_total", nonskip_sent, req_count);
    for (int i = 0; i < CORES; i++) begin
      check_count($sformatf("queue_left_core%0d", i), 0, tail[i] - head[i]);
    end
    check_flag("idle_out_valid", 1'b0, dram_out_valid);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verilog
verilog/fabric_pkg.sv
verilog/ctrl_route_stage.sv
verilog/dram_req_gen.sv
verilog/dram_req_arb.sv
verilog/core_cluster.sv
verilog/ctrl_dram_fabric.sv
dv/tb_clock_gen.sv
dv/tb_ctrl_dram_fabric.sv
